//--- design/adapter_defs.svh
/* adapter widths and queue depths shared by the packages and the RTL */

`ifndef ADAPTER_DEFS_SVH
`define ADAPTER_DEFS_SVH

// physical address and bus beat
`define ADPT_PADDR_W     32
`define ADPT_BUS_DATA_W  64

// cache line, same for both caches
`define ADPT_LINE_W      128
`define ADPT_LINE_BEATS  2

// byte offset within one bus beat
`define ADPT_BEAT_OFF_W  3

// cache transaction id
`define ADPT_TID_W       2

// request queues and tracking queues
`define ADPT_REQ_DEPTH   2
`define ADPT_META_DEPTH  4

`endif

//--- design/cache_msg_pkg.sv
/* cache side messages: miss requests from the instruction and data
   caches and the return packets sent back to them */

`include "adapter_defs.svh"

package cache_msg_pkg;

  // dcache request opcode
  typedef enum logic {
    DC_LOAD,
    DC_STORE
  } dc_req_type_e;

  typedef enum logic {
    DC_LOAD_ACK,
    DC_STORE_ACK
  } dc_rtrn_type_e;

  typedef struct packed {
    logic [`ADPT_PADDR_W-1:0] paddr;
    logic                     nc;
    logic [`ADPT_TID_W-1:0]   tid;
  } ic_req_t;

  // size[2] asks for a full line
  typedef struct packed {
    dc_req_type_e                rtype;
    logic [`ADPT_PADDR_W-1:0]    paddr;
    logic [2:0]                  size;
    logic [`ADPT_BUS_DATA_W-1:0] data;
    logic [`ADPT_TID_W-1:0]      tid;
  } dc_req_t;

  typedef struct packed {
    logic [`ADPT_TID_W-1:0]  tid;
    logic [`ADPT_LINE_W-1:0] data;
  } ic_rtrn_t;

  typedef struct packed {
    dc_rtrn_type_e           rtype;
    logic [`ADPT_TID_W-1:0]  tid;
    logic [`ADPT_LINE_W-1:0] data;
  } dc_rtrn_t;

endpackage

//--- design/mem_bus_pkg.sv
/* memory bus commands and beats, with the source id that routes them */

`include "adapter_defs.svh"

package mem_bus_pkg;

  // one id bit, one per cache
  typedef enum logic {
    SRC_ICACHE = 1'b0,
    SRC_DCACHE = 1'b1
  } bus_src_e;

  typedef struct packed {
    logic [`ADPT_PADDR_W-1:0] addr;
    logic                     blen;
    logic [2:0]               size;
    bus_src_e                 id;
  } bus_rd_cmd_t;

  typedef struct packed {
    logic [`ADPT_PADDR_W-1:0]      addr;
    logic [`ADPT_BUS_DATA_W-1:0]   data;
    logic [`ADPT_BUS_DATA_W/8-1:0] be;
    logic [2:0]                    size;
    bus_src_e                      id;
  } bus_wr_cmd_t;

  typedef struct packed {
    logic [`ADPT_BUS_DATA_W-1:0] data;
    bus_src_e                    id;
    logic                        last;
  } bus_rd_beat_t;

endpackage

//--- design/sync_fifo.sv
/* synchronous FIFO: circular buffer with a count, an empty queue can
   optionally pass its input straight through */

module sync_fifo #(
  parameter type         data_t       = logic,
  parameter int unsigned depth        = 2,
  parameter bit          fall_through = 1'b0
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  data_t data_i,
  input  logic  pop_i,
  output data_t data_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  data_t            mem_q [depth];
  logic [ptr_w-1:0] rd_ptr_q, wr_ptr_q;
  logic [cnt_w-1:0] cnt_q;
  logic             bypass, do_push, do_pop;

  // push and pop on an empty fall-through queue never touch the buffer
  assign bypass  = fall_through && (cnt_q == '0) && push_i && pop_i;
  assign do_push = push_i && !full_o && !bypass;
  assign do_pop  = pop_i && (cnt_q != '0);
  assign full_o  = (cnt_q == cnt_w'(depth));

  always_comb begin
    data_o  = mem_q[rd_ptr_q];
    empty_o = (cnt_q == '0);
    if (fall_through && (cnt_q == '0)) begin
      data_o  = data_i;
      empty_o = !push_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + cnt_w'(do_push) - cnt_w'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // the producer must look at full_o, the consumer at empty_o
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && full_o));
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pop_i && empty_o));

endmodule

//--- design/req_arbiter.sv
/* round-robin arbiter between the icache and dcache queue heads that
   holds its choice until the bus grants it */

module req_arbiter import mem_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     ic_valid_i,
  input  logic     dc_valid_i,
  input  logic     gnt_i,
  output bus_src_e sel_o,
  output logic     ic_pop_o,
  output logic     dc_pop_o
);

  logic     req;
  logic     lock_q;
  bus_src_e lock_sel_q, prio_q;

  assign req = ic_valid_i | dc_valid_i;

  always_comb begin
    if (lock_q) begin
      sel_o = lock_sel_q;
    end else if (ic_valid_i && dc_valid_i) begin
      sel_o = prio_q;
    end else if (dc_valid_i) begin
      sel_o = SRC_DCACHE;
    end else begin
      sel_o = SRC_ICACHE;
    end
  end

  // the granted head leaves its queue
  assign ic_pop_o = req && gnt_i && (sel_o == SRC_ICACHE);
  assign dc_pop_o = req && gnt_i && (sel_o == SRC_DCACHE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q     <= 1'b0;
      lock_sel_q <= SRC_ICACHE;
      prio_q     <= SRC_ICACHE;
    end else if (req) begin
      if (gnt_i) begin
        lock_q <= 1'b0;
        prio_q <= (sel_o == SRC_ICACHE) ? SRC_DCACHE : SRC_ICACHE;
      end else begin
        lock_q     <= 1'b1;
        lock_sel_q <= sel_o;
      end
    end
  end

  // a waiting bus command must not switch source or lose its head
  a_sel_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req && !gnt_i) |=> $stable(sel_o) &&
      ((sel_o == SRC_ICACHE) ? ic_valid_i : dc_valid_i));

endmodule

//--- design/bus_req_encoder.sv
/* bus command encoder: maps the selected queue head onto a read or a
   write command, with byte enables for stores */

`include "adapter_defs.svh"

module bus_req_encoder import cache_msg_pkg::*; import mem_bus_pkg::*; (
  input  bus_src_e    sel_i,
  input  ic_req_t     ic_head_i,
  input  dc_req_t     dc_head_i,
  input  logic        req_valid_i,
  output logic        rd_req_o,
  output bus_rd_cmd_t rd_cmd_o,
  output logic        wr_req_o,
  output bus_wr_cmd_t wr_cmd_o
);

  localparam int unsigned be_w      = `ADPT_BUS_DATA_W / 8;
  localparam logic [2:0]  full_size = 3'(`ADPT_BEAT_OFF_W);
  localparam logic        line_blen = 1'(`ADPT_LINE_BEATS - 1);

  logic [be_w-1:0]             be_mask;
  logic [`ADPT_BEAT_OFF_W-1:0] byte_off;

  //////////////////////////////////////////////////////////////////////////
  // read channel
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_cmd_o.addr = ic_head_i.paddr;
    rd_cmd_o.blen = 1'b0;
    rd_cmd_o.size = full_size;
    rd_cmd_o.id   = sel_i;
    if (sel_i == SRC_ICACHE) begin
      // ifills always read whole beats, nc fetches only one
      if (!ic_head_i.nc) begin
        rd_cmd_o.blen = line_blen;
      end
    end else begin
      rd_cmd_o.addr = dc_head_i.paddr;
      if (dc_head_i.size[2]) begin
        rd_cmd_o.blen = line_blen;
      end else begin
        rd_cmd_o.size = dc_head_i.size;
      end
    end
  end

  assign rd_req_o = req_valid_i &&
                    ((sel_i == SRC_ICACHE) || (dc_head_i.rtype == DC_LOAD));
  assign wr_req_o = req_valid_i && (sel_i == SRC_DCACHE) &&
                    (dc_head_i.rtype == DC_STORE);

  //////////////////////////////////////////////////////////////////////////
  // write channel
  //////////////////////////////////////////////////////////////////////////

  assign byte_off = dc_head_i.paddr[`ADPT_BEAT_OFF_W-1:0];

  // byte, half, word or double word
  always_comb begin
    unique case (dc_head_i.size[1:0])
      2'b00:   be_mask = be_w'(1);
      2'b01:   be_mask = be_w'(3);
      2'b10:   be_mask = be_w'(15);
      default: be_mask = '1;
    endcase
  end

  assign wr_cmd_o.addr = dc_head_i.paddr;
  assign wr_cmd_o.data = dc_head_i.data;
  assign wr_cmd_o.be   = be_mask << byte_off;
  assign wr_cmd_o.size = dc_head_i.size;
  assign wr_cmd_o.id   = SRC_DCACHE;

endmodule

//--- design/tid_tracker.sv
/* transaction id tracking: in-order queues of granted tids for icache
   reads, dcache reads and dcache writes */

`include "adapter_defs.svh"

module tid_tracker import mem_bus_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`ADPT_TID_W-1:0] tid_i,
  input  bus_src_e               sel_i,
  input  logic                   rd_gnt_i,
  input  logic                   wr_gnt_i,
  input  logic                   ic_rd_pop_i,
  input  logic                   dc_rd_pop_i,
  input  logic                   dc_wr_pop_i,
  output logic [`ADPT_TID_W-1:0] ic_rd_tid_o,
  output logic [`ADPT_TID_W-1:0] dc_rd_tid_o,
  output logic [`ADPT_TID_W-1:0] dc_wr_tid_o,
  output logic                   ic_room_o,
  output logic                   dc_room_o
);

  typedef logic [`ADPT_TID_W-1:0] tid_t;

  logic ic_rd_full, dc_rd_full, dc_wr_full;
  logic ic_rd_push, dc_rd_push, dc_wr_push;

  assign ic_rd_push = rd_gnt_i && (sel_i == SRC_ICACHE);
  assign dc_rd_push = rd_gnt_i && (sel_i == SRC_DCACHE);
  assign dc_wr_push = wr_gnt_i && (sel_i == SRC_DCACHE);

  // a dcache head may turn into either direction
  assign ic_room_o = !ic_rd_full;
  assign dc_room_o = !dc_rd_full && !dc_wr_full;

  sync_fifo #(
    .data_t (tid_t),
    .depth  (`ADPT_META_DEPTH)
  ) i_ic_rd_tid (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (ic_rd_push),
    .data_i  (tid_i),
    .pop_i   (ic_rd_pop_i),
    .data_o  (ic_rd_tid_o),
    .full_o  (ic_rd_full),
    .empty_o ()
  );

  sync_fifo #(
    .data_t (tid_t),
    .depth  (`ADPT_META_DEPTH)
  ) i_dc_rd_tid (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (dc_rd_push),
    .data_i  (tid_i),
    .pop_i   (dc_rd_pop_i),
    .data_o  (dc_rd_tid_o),
    .full_o  (dc_rd_full),
    .empty_o ()
  );

  sync_fifo #(
    .data_t (tid_t),
    .depth  (`ADPT_META_DEPTH)
  ) i_dc_wr_tid (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (dc_wr_push),
    .data_i  (tid_i),
    .pop_i   (dc_wr_pop_i),
    .data_o  (dc_wr_tid_o),
    .full_o  (dc_wr_full),
    .empty_o ()
  );

endmodule

//--- design/rtrn_assembler.sv
/* return path: shifts read beats into cache lines, buffers write
   responses and registers one return packet per transaction */

`include "adapter_defs.svh"

module rtrn_assembler import cache_msg_pkg::*; import mem_bus_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rd_valid_i,
  input  bus_rd_beat_t           rd_beat_i,
  input  logic                   wr_rsp_valid_i,
  input  bus_src_e               wr_rsp_id_i,
  output logic                   wr_rsp_ready_o,
  input  logic [`ADPT_TID_W-1:0] ic_rd_tid_i,
  input  logic [`ADPT_TID_W-1:0] dc_rd_tid_i,
  input  logic [`ADPT_TID_W-1:0] dc_wr_tid_i,
  output logic                   ic_rd_pop_o,
  output logic                   dc_rd_pop_o,
  output logic                   dc_wr_pop_o,
  output logic                   icache_rtrn_vld_o,
  output ic_rtrn_t               icache_rtrn_o,
  output logic                   dcache_rtrn_vld_o,
  output dc_rtrn_t               dcache_rtrn_o
);

  typedef logic [`ADPT_LINE_BEATS-1:0][`ADPT_BUS_DATA_W-1:0] line_t;

  logic                   b_full, b_empty, b_push, b_pop;
  bus_src_e               b_id;
  logic [1:0]             beat_en;
  logic [1:0]             first_d, first_q;
  line_t                  line_d [2];
  line_t                  line_q [2];
  logic                   ic_vld_q, dc_vld_q, dc_vld_d;
  logic [`ADPT_TID_W-1:0] ic_tid_q, dc_tid_q, dc_tid_d;
  dc_rtrn_type_e          dc_type_q, dc_type_d;

  //////////////////////////////////////////////////////////////////////////
  // write response buffer
  //////////////////////////////////////////////////////////////////////////

  assign wr_rsp_ready_o = !b_full;
  assign b_push         = wr_rsp_valid_i && wr_rsp_ready_o;

  sync_fifo #(
    .data_t       (bus_src_e),
    .depth        (`ADPT_META_DEPTH),
    .fall_through (1'b1)
  ) i_wr_rsp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (b_push),
    .data_i  (wr_rsp_id_i),
    .pop_i   (b_pop),
    .data_o  (b_id),
    .full_o  (b_full),
    .empty_o (b_empty)
  );

  //////////////////////////////////////////////////////////////////////////
  // read beat shift registers, one per cache
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      beat_en[s] = rd_valid_i && (rd_beat_i.id == bus_src_e'(s));
      line_d[s]  = line_q[s];
      first_d[s] = first_q[s];
      if (beat_en[s]) begin
        first_d[s] = rd_beat_i.last;
        line_d[s]  = {rd_beat_i.data, line_q[s][`ADPT_LINE_BEATS-1:1]};
        // a single beat transaction must end up in word 0
        if (first_q[s]) begin
          line_d[s][0] = rd_beat_i.data;
        end
      end
    end
  end

  assign ic_rd_pop_o = beat_en[SRC_ICACHE] && rd_beat_i.last;
  assign dc_rd_pop_o = beat_en[SRC_DCACHE] && rd_beat_i.last;

  // dcache read beats win, the response waits in its queue
  assign b_pop       = !b_empty && !beat_en[SRC_DCACHE];
  assign dc_wr_pop_o = b_pop && (b_id == SRC_DCACHE);

  assign dc_vld_d  = dc_rd_pop_o || dc_wr_pop_o;
  assign dc_type_d = dc_wr_pop_o ? DC_STORE_ACK : DC_LOAD_ACK;
  assign dc_tid_d  = dc_wr_pop_o ? dc_wr_tid_i : dc_rd_tid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q  <= '1;
      ic_vld_q <= 1'b0;
      dc_vld_q <= 1'b0;
    end else begin
      first_q  <= first_d;
      ic_vld_q <= ic_rd_pop_o;
      dc_vld_q <= dc_vld_d;
    end
  end

  always_ff @(posedge clk_i) begin
    line_q[0] <= line_d[0];
    line_q[1] <= line_d[1];
    ic_tid_q  <= ic_rd_tid_i;
    dc_tid_q  <= dc_tid_d;
    dc_type_q <= dc_type_d;
  end

  // return packets straight from registers
  assign icache_rtrn_vld_o   = ic_vld_q;
  assign icache_rtrn_o.tid   = ic_tid_q;
  assign icache_rtrn_o.data  = line_q[SRC_ICACHE];
  assign dcache_rtrn_vld_o   = dc_vld_q;
  assign dcache_rtrn_o.rtype = dc_type_q;
  assign dcache_rtrn_o.tid   = dc_tid_q;
  assign dcache_rtrn_o.data  = line_q[SRC_DCACHE];

  // only the dcache issues writes
  a_wr_rsp_dcache: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_rsp_valid_i |-> (wr_rsp_id_i == SRC_DCACHE));

endmodule

//--- design/cache_mem_adapter.sv
/* cache to memory bus adapter: queues icache and dcache misses,
   arbitrates them onto the split bus and returns one packet per miss */

`include "adapter_defs.svh"

module cache_mem_adapter import cache_msg_pkg::*; import mem_bus_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // icache
  input  logic         icache_req_i,
  output logic         icache_ack_o,
  input  ic_req_t      icache_data_i,
  output logic         icache_rtrn_vld_o,
  output ic_rtrn_t     icache_rtrn_o,
  // dcache
  input  logic         dcache_req_i,
  output logic         dcache_ack_o,
  input  dc_req_t      dcache_data_i,
  output logic         dcache_rtrn_vld_o,
  output dc_rtrn_t     dcache_rtrn_o,
  // bus read side
  output logic         bus_rd_req_o,
  output bus_rd_cmd_t  bus_rd_cmd_o,
  input  logic         bus_rd_gnt_i,
  input  logic         bus_rd_valid_i,
  input  bus_rd_beat_t bus_rd_beat_i,
  // bus write side
  output logic         bus_wr_req_o,
  output bus_wr_cmd_t  bus_wr_cmd_o,
  input  logic         bus_wr_gnt_i,
  input  logic         bus_wr_rsp_valid_i,
  input  bus_src_e     bus_wr_rsp_id_i,
  output logic         bus_wr_rsp_ready_o
);

  ic_req_t                ic_head;
  dc_req_t                dc_head;
  logic                   ic_full, ic_empty, dc_full, dc_empty;
  logic                   ic_pop, dc_pop, ic_room, dc_room;
  logic                   ic_elig, dc_elig, req_valid, gnt;
  bus_src_e               sel;
  logic [`ADPT_TID_W-1:0] sel_tid, ic_rd_tid, dc_rd_tid, dc_wr_tid;
  logic                   ic_rd_pop, dc_rd_pop, dc_wr_pop;

  ////////////////////////////////////////////////////////////////////////////
  // request queues and arbitration
  ////////////////////////////////////////////////////////////////////////////

  assign icache_ack_o = icache_req_i && !ic_full;
  assign dcache_ack_o = dcache_req_i && !dc_full;

  sync_fifo #(
    .data_t (ic_req_t),
    .depth  (`ADPT_REQ_DEPTH)
  ) i_ic_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (icache_ack_o),
    .data_i  (icache_data_i),
    .pop_i   (ic_pop),
    .data_o  (ic_head),
    .full_o  (ic_full),
    .empty_o (ic_empty)
  );

  sync_fifo #(
    .data_t (dc_req_t),
    .depth  (`ADPT_REQ_DEPTH)
  ) i_dc_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (dcache_ack_o),
    .data_i  (dcache_data_i),
    .pop_i   (dc_pop),
    .data_o  (dc_head),
    .full_o  (dc_full),
    .empty_o (dc_empty)
  );

  // a head waits while its tid queue has no room
  assign ic_elig   = !ic_empty && ic_room;
  assign dc_elig   = !dc_empty && dc_room;
  assign req_valid = ic_elig || dc_elig;
  assign gnt       = bus_rd_gnt_i || bus_wr_gnt_i;

  req_arbiter i_req_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ic_valid_i (ic_elig),
    .dc_valid_i (dc_elig),
    .gnt_i      (gnt),
    .sel_o      (sel),
    .ic_pop_o   (ic_pop),
    .dc_pop_o   (dc_pop)
  );

  bus_req_encoder i_bus_req_encoder (
    .sel_i       (sel),
    .ic_head_i   (ic_head),
    .dc_head_i   (dc_head),
    .req_valid_i (req_valid),
    .rd_req_o    (bus_rd_req_o),
    .rd_cmd_o    (bus_rd_cmd_o),
    .wr_req_o    (bus_wr_req_o),
    .wr_cmd_o    (bus_wr_cmd_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // tracking and return path
  ////////////////////////////////////////////////////////////////////////////

  assign sel_tid = (sel == SRC_ICACHE) ? ic_head.tid : dc_head.tid;

  tid_tracker i_tid_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tid_i       (sel_tid),
    .sel_i       (sel),
    .rd_gnt_i    (bus_rd_gnt_i),
    .wr_gnt_i    (bus_wr_gnt_i),
    .ic_rd_pop_i (ic_rd_pop),
    .dc_rd_pop_i (dc_rd_pop),
    .dc_wr_pop_i (dc_wr_pop),
    .ic_rd_tid_o (ic_rd_tid),
    .dc_rd_tid_o (dc_rd_tid),
    .dc_wr_tid_o (dc_wr_tid),
    .ic_room_o   (ic_room),
    .dc_room_o   (dc_room)
  );

  rtrn_assembler i_rtrn_assembler (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rd_valid_i        (bus_rd_valid_i),
    .rd_beat_i         (bus_rd_beat_i),
    .wr_rsp_valid_i    (bus_wr_rsp_valid_i),
    .wr_rsp_id_i       (bus_wr_rsp_id_i),
    .wr_rsp_ready_o    (bus_wr_rsp_ready_o),
    .ic_rd_tid_i       (ic_rd_tid),
    .dc_rd_tid_i       (dc_rd_tid),
    .dc_wr_tid_i       (dc_wr_tid),
    .ic_rd_pop_o       (ic_rd_pop),
    .dc_rd_pop_o       (dc_rd_pop),
    .dc_wr_pop_o       (dc_wr_pop),
    .icache_rtrn_vld_o (icache_rtrn_vld_o),
    .icache_rtrn_o     (icache_rtrn_o),
    .dcache_rtrn_vld_o (dcache_rtrn_vld_o),
    .dcache_rtrn_o     (dcache_rtrn_o)
  );

endmodule

//--- dv/mem_model.sv
/* behavioral memory bus model: grants after random delays, returns read
   beats in command order and answers writes in order */

module mem_model import mem_bus_pkg::*; #(
  parameter logic [63:0] pattern   = 64'h5a5a_0000_a5a5_0000,
  parameter int unsigned seed_init = 32'hcb830edc
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         rd_req_i,
  input  bus_rd_cmd_t  rd_cmd_i,
  output logic         rd_gnt_o,
  output logic         rd_valid_o,
  output bus_rd_beat_t rd_beat_o,
  input  logic         wr_req_i,
  input  bus_wr_cmd_t  wr_cmd_i,
  output logic         wr_gnt_o,
  output logic         wr_rsp_valid_o,
  output bus_src_e     wr_rsp_id_o,
  input  logic         wr_rsp_ready_i
);

  bus_rd_cmd_t rd_q [$];
  bus_src_e    wr_q [$];
  int unsigned beat_idx;
  integer      seed;
  logic [31:0] rnd;
  logic [31:0] beat_addr;

  initial begin
    seed           = seed_init;
    beat_idx       = 0;
    rd_gnt_o       = 1'b0;
    rd_valid_o     = 1'b0;
    rd_beat_o      = '0;
    wr_gnt_o       = 1'b0;
    wr_rsp_valid_o = 1'b0;
    wr_rsp_id_o    = SRC_DCACHE;
  end

  always @(posedge clk_i) begin
    // bookkeeping of what was exchanged in the cycle that just ended
    if (!rst_ni) begin
      rd_q.delete();
      wr_q.delete();
      beat_idx = 0;
    end else begin
      if (rd_req_i && rd_gnt_o) begin
        rd_q.push_back(rd_cmd_i);
      end
      if (wr_req_i && wr_gnt_o) begin
        wr_q.push_back(wr_cmd_i.id);
      end
      if (rd_valid_o) begin
        if (rd_beat_o.last) begin
          void'(rd_q.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      if (wr_rsp_valid_o && wr_rsp_ready_i) begin
        void'(wr_q.pop_front());
      end
    end
    #2;
    rnd = $random(seed);
    if (!rst_ni) begin
      rd_gnt_o       = 1'b0;
      wr_gnt_o       = 1'b0;
      rd_valid_o     = 1'b0;
      wr_rsp_valid_o = 1'b0;
    end else begin
      // grant roughly one cycle in four while a command waits
      rd_gnt_o = rd_req_i && (rnd[1:0] == 2'b00);
      wr_gnt_o = wr_req_i && (rnd[1:0] == 2'b00);
      rd_valid_o = 1'b0;
      if (rd_q.size() != 0 && rnd[2]) begin
        beat_addr        = {rd_q[0].addr[31:3], 3'b000} + 32'(8 * beat_idx);
        rd_valid_o       = 1'b1;
        rd_beat_o.data   = {32'h0, beat_addr} ^ pattern;
        rd_beat_o.id     = rd_q[0].id;
        rd_beat_o.last   = (beat_idx == int'(rd_q[0].blen));
      end
      wr_rsp_valid_o = (wr_q.size() != 0) && rnd[3];
      if (wr_q.size() != 0) begin
        wr_rsp_id_o = wr_q[0];
      end
    end
  end

endmodule

//--- dv/tb_cache_mem_adapter.sv
/* testbench for the cache to memory bus adapter with directed and random
   misses checked by assertions against scoreboard queues */

`include "adapter_defs.svh"

module tb_cache_mem_adapter import cache_msg_pkg::*; import mem_bus_pkg::*; ();

  localparam logic [63:0] pat   = 64'h5a5a_0000_a5a5_0000;
  localparam int          limit = 2000;

  typedef struct packed {
    logic                    full;
    logic [`ADPT_TID_W-1:0]  tid;
    logic [`ADPT_LINE_W-1:0] data;
  } exp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  be;
  } exp_wr_t;

  logic         clk_i, rst_ni;
  logic         icache_req_i, icache_ack_o, icache_rtrn_vld_o;
  ic_req_t      icache_data_i;
  ic_rtrn_t     icache_rtrn_o;
  logic         dcache_req_i, dcache_ack_o, dcache_rtrn_vld_o;
  dc_req_t      dcache_data_i;
  dc_rtrn_t     dcache_rtrn_o;
  logic         bus_rd_req_o, bus_rd_gnt_i, bus_rd_valid_i;
  bus_rd_cmd_t  bus_rd_cmd_o;
  bus_rd_beat_t bus_rd_beat_i;
  logic         bus_wr_req_o, bus_wr_gnt_i, bus_wr_rsp_valid_i, bus_wr_rsp_ready_o;
  bus_wr_cmd_t  bus_wr_cmd_o;
  bus_src_e     bus_wr_rsp_id_i;

  exp_t    exp_ic [$];
  exp_t    exp_ld [$];
  exp_t    exp_st [$];
  exp_wr_t exp_wr [$];
  exp_t    ic_head, ld_head, st_head;
  exp_wr_t wr_head;
  logic    ic_have, ld_have, st_have, wr_have;
  logic    ic_ok, ld_ok, st_ok, wr_ok;
  integer  seed;

  cache_mem_adapter i_cache_mem_adapter (.*);

  mem_model i_mem_model (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rd_req_i       (bus_rd_req_o),
    .rd_cmd_i       (bus_rd_cmd_o),
    .rd_gnt_o       (bus_rd_gnt_i),
    .rd_valid_o     (bus_rd_valid_i),
    .rd_beat_o      (bus_rd_beat_i),
    .wr_req_i       (bus_wr_req_o),
    .wr_cmd_i       (bus_wr_cmd_o),
    .wr_gnt_o       (bus_wr_gnt_i),
    .wr_rsp_valid_o (bus_wr_rsp_valid_i),
    .wr_rsp_id_o    (bus_wr_rsp_id_i),
    .wr_rsp_ready_i (bus_wr_rsp_ready_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [127:0] line_pattern(input logic [31:0] addr);
    logic [63:0] w0, w1;
    w0 = {32'h0, addr} ^ pat;
    w1 = {32'h0, addr + 32'd8} ^ pat;
    return {w1, w0};
  endfunction

  // size 0..3 selects 1, 2, 4 or 8 bytes from the offset upward
  function automatic logic [7:0] store_be(input logic [1:0] sz, input logic [2:0] off);
    logic [15:0] m;
    m = (16'd1 << (1 << sz)) - 16'd1;
    m = m << off;
    return m[7:0];
  endfunction

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic report_mismatch(input string name, input logic [159:0] exp,
                                 input logic [159:0] act);
    $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    stop_run();
  endtask

  task automatic issue_ic(input logic [31:0] addr, input logic nc, input logic [1:0] tid);
    int   n;
    logic acked;
    icache_req_i  = 1'b1;
    icache_data_i = '{paddr: addr, nc: nc, tid: tid};
    n     = 0;
    acked = 1'b0;
    while (!acked) begin
      @(posedge clk_i);
      acked = icache_ack_o;
      n++;
      if (!acked && n >= limit) begin
        $display("timeout while the icache request waited for its ack");
        stop_run();
      end
    end
    exp_ic.push_back('{full: !nc, tid: tid, data: line_pattern(addr)});
    #2;
    icache_req_i = 1'b0;
  endtask

  task automatic issue_dc(input dc_req_type_e rtype, input logic [31:0] addr,
                          input logic [2:0] size, input logic [63:0] data,
                          input logic [1:0] tid);
    int   n;
    logic acked;
    dcache_req_i  = 1'b1;
    dcache_data_i = '{rtype: rtype, paddr: addr, size: size, data: data, tid: tid};
    n     = 0;
    acked = 1'b0;
    while (!acked) begin
      @(posedge clk_i);
      acked = dcache_ack_o;
      n++;
      if (!acked && n >= limit) begin
        $display("timeout while the dcache request waited for its ack");
        stop_run();
      end
    end
    if (rtype == DC_STORE) begin
      exp_st.push_back('{full: 1'b0, tid: tid, data: '0});
      exp_wr.push_back('{addr: addr, data: data, be: store_be(size[1:0], addr[2:0])});
    end else begin
      exp_ld.push_back('{full: size[2], tid: tid, data: line_pattern(addr)});
    end
    #2;
    dcache_req_i = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_ic.size() + exp_ld.size() + exp_st.size() + exp_wr.size() != 0) begin
      @(posedge clk_i);
      n++;
      if (n >= limit) begin
        $display("timeout with returns still outstanding");
        stop_run();
      end
    end
    #2;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // scoreboard heads refreshed mid-cycle while nothing moves
  //////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    ic_have = exp_ic.size() != 0;
    ld_have = exp_ld.size() != 0;
    st_have = exp_st.size() != 0;
    wr_have = exp_wr.size() != 0;
    ic_head = ic_have ? exp_ic[0] : '0;
    ld_head = ld_have ? exp_ld[0] : '0;
    st_head = st_have ? exp_st[0] : '0;
    wr_head = wr_have ? exp_wr[0] : '0;
  end

  assign ic_ok = ic_have && (icache_rtrn_o.tid == ic_head.tid) &&
                 (ic_head.full ? icache_rtrn_o.data == ic_head.data
                               : icache_rtrn_o.data[63:0] == ic_head.data[63:0]);
  assign ld_ok = ld_have && (dcache_rtrn_o.tid == ld_head.tid) &&
                 (ld_head.full ? dcache_rtrn_o.data == ld_head.data
                               : dcache_rtrn_o.data[63:0] == ld_head.data[63:0]);
  assign st_ok = st_have && (dcache_rtrn_o.tid == st_head.tid);
  assign wr_ok = wr_have && (bus_wr_cmd_o.addr == wr_head.addr) &&
                 (bus_wr_cmd_o.data == wr_head.data) && (bus_wr_cmd_o.be == wr_head.be);

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (icache_rtrn_vld_o && ic_have) begin
        void'(exp_ic.pop_front());
      end
      if (dcache_rtrn_vld_o && dcache_rtrn_o.rtype == DC_LOAD_ACK && ld_have) begin
        void'(exp_ld.pop_front());
      end
      if (dcache_rtrn_vld_o && dcache_rtrn_o.rtype == DC_STORE_ACK && st_have) begin
        void'(exp_st.pop_front());
      end
      if (bus_wr_req_o && bus_wr_gnt_i && wr_have) begin
        void'(exp_wr.pop_front());
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    ((!rst_ni && $past(!rst_ni)) || $rose(rst_ni)) |->
    (!(icache_rtrn_vld_o || dcache_rtrn_vld_o || bus_rd_req_o || bus_wr_req_o) &&
     bus_wr_rsp_ready_o))
    else report_mismatch("reset_quiet", 5'b00001,
                         $sampled({icache_rtrn_vld_o, dcache_rtrn_vld_o, bus_rd_req_o,
                                   bus_wr_req_o, bus_wr_rsp_ready_o}));

  a_ic_rtrn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    icache_rtrn_vld_o |-> ic_ok)
    else report_mismatch("icache_return", $sampled({ic_head.tid, ic_head.data}),
                         $sampled({icache_rtrn_o.tid, icache_rtrn_o.data}));

  a_dc_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dcache_rtrn_vld_o && dcache_rtrn_o.rtype == DC_LOAD_ACK) |-> ld_ok)
    else report_mismatch("dcache_load", $sampled({ld_head.tid, ld_head.data}),
                         $sampled({dcache_rtrn_o.tid, dcache_rtrn_o.data}));

  a_dc_store: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dcache_rtrn_vld_o && dcache_rtrn_o.rtype == DC_STORE_ACK) |-> st_ok)
    else report_mismatch("store_ack", $sampled(st_head.tid), $sampled(dcache_rtrn_o.tid));

  a_wr_cmd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_wr_req_o && bus_wr_gnt_i) |-> wr_ok)
    else report_mismatch("write_command", $sampled({wr_head.addr, wr_head.data, wr_head.be}),
                         $sampled({bus_wr_cmd_o.addr, bus_wr_cmd_o.data, bus_wr_cmd_o.be}));

  //////////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [2:0]  off;
    seed          = 32'hcb830edc;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    icache_req_i  = 1'b0;
    icache_data_i = '0;
    dcache_req_i  = 1'b0;
    dcache_data_i = '0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;

    // directed fills and loads
    issue_ic(32'h0000_1230, 1'b0, 2'd1);
    wait_drained();
    issue_ic(32'h0000_2348, 1'b1, 2'd2);
    issue_dc(DC_LOAD, 32'h0000_3458, 3'b011, 64'h0, 2'd3);
    wait_drained();
    issue_dc(DC_LOAD, 32'h0000_4560, 3'b111, 64'h0, 2'd0);
    wait_drained();

    // one store of each size
    issue_dc(DC_STORE, 32'h0000_5005, 3'b000, 64'h1111_2222_3333_4444, 2'd1);
    issue_dc(DC_STORE, 32'h0000_5012, 3'b001, 64'h5555_6666_7777_8888, 2'd2);
    issue_dc(DC_STORE, 32'h0000_5024, 3'b010, 64'h9999_aaaa_bbbb_cccc, 2'd3);
    issue_dc(DC_STORE, 32'h0000_5038, 3'b011, 64'hdddd_eeee_ffff_0123, 2'd0);
    wait_drained();

    // interleaved random traffic from both caches
    fork
      for (int i = 0; i < 16; i++) begin
        r = $random(seed);
        issue_ic({r[31:4], 4'h0} | {28'h0, r[0], 3'b000} & {32{r[1]}}, r[1], 2'(i));
      end
      for (int i = 0; i < 16; i++) begin
        r   = $random(seed);
        off = r[6:4] & ~3'((1 << r[9:8]) - 1);
        case (r[1:0])
          2'b00:   issue_dc(DC_LOAD, {r[31:4], 4'h0}, 3'b111, 64'h0, 2'(i));
          2'b01:   issue_dc(DC_LOAD, {r[31:4], r[3], 3'b000}, 3'b011, 64'h0, 2'(i));
          default: issue_dc(DC_STORE, {r[31:7], 4'h0, off}, {1'b0, r[9:8]},
                            {$random(seed), $random(seed)}, 2'(i));
        endcase
      end
    join
    wait_drained();

    $display("TEST OK");
    $finish;
  end

endmodule

//--- Bender.yml
package:
  name: cache_mem_adapter

sources:
  - include_dirs:
      - design
    files:
      - design/cache_msg_pkg.sv
      - design/mem_bus_pkg.sv
      - design/sync_fifo.sv
      - design/req_arbiter.sv
      - design/bus_req_encoder.sv
      - design/tid_tracker.sv
      - design/rtrn_assembler.sv
      - design/cache_mem_adapter.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/mem_model.sv
      - dv/tb_cache_mem_adapter.sv

//--- cache_mem_adapter.f
+incdir+design
design/cache_msg_pkg.sv
design/mem_bus_pkg.sv
design/sync_fifo.sv
design/req_arbiter.sv
design/bus_req_encoder.sv
design/tid_tracker.sv
design/rtrn_assembler.sv
design/cache_mem_adapter.sv
dv/mem_model.sv
dv/tb_cache_mem_adapter.sv
